// ==== hw/axi_read_pkg.sv ====
// Field types of the AXI-style read channels (AR and R).
// Import where a module carries request or response fields.

package axi_read_pkg;

  // --------------------
  // Field widths
  // --------------------
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned ID_W   = 4;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ID_W-1:0]   id_t;

  // Beats minus one, as on the bus
  typedef logic [7:0] len_t;

  // Log2 of bytes per beat
  typedef logic [2:0] size_t;

  typedef logic [1:0] burst_t;

  // --------------------
  // Burst kinds
  // --------------------
  localparam burst_t BURST_FIXED = 2'b00;
  localparam burst_t BURST_INCR  = 2'b01;
  localparam burst_t BURST_WRAP  = 2'b10;

endpackage

// ==== hw/splitter_pkg.sv ====
// Internal types shared by the burst splitter blocks.
// Holds the beat counter width and the request FSM states.

package splitter_pkg;

  // One more bit than len, so a full 256-beat burst fits
  localparam int unsigned BEAT_CNT_W = 9;

  typedef logic [BEAT_CNT_W-1:0] beat_cnt_t;

  // --------------------
  // Request splitter FSM
  // --------------------
  typedef enum logic {
    Idle,
    Busy
  } split_state_e;

endpackage

// ==== hw/slot_if.sv ====
// Link between one beat-count slot, the request side that fills it
// and the response side that drains it. One instance per slot.

`timescale 1ns/1ps

interface slot_if import splitter_pkg::*; ();

  logic      load;
  beat_cnt_t load_count;
  logic      dec;
  beat_cnt_t count;
  logic      busy;

  // Request splitter side
  modport filler (output load, output load_count, input busy);

  // The slot itself
  modport counter (input load, input load_count, input dec, output count, output busy);

  // Response side
  modport drainer (output dec, input count, input busy);

endinterface

// ==== hw/beat_count_slot.sv ====
// Beat counter for one outstanding burst. Loaded with the burst's beat
// count when the request is accepted, counted down per response beat.
// Busy while any beat is still owed.

`timescale 1ns/1ps

module beat_count_slot import splitter_pkg::*; (
  input logic     clk_i,
  input logic     rst_i,
  slot_if.counter slot
);

  beat_cnt_t count_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      count_q <= '0;
    end else if (slot.load) begin
      count_q <= slot.load_count;
    end else if (slot.dec) begin
      count_q <= count_q - beat_cnt_t'(1);
    end
  end

  assign slot.count = count_q;
  assign slot.busy  = (count_q != '0);

  // --------------------
  // Checks
  // --------------------
  // Filler must wait for the drainer to free the slot
  assert property (@(posedge clk_i) disable iff (rst_i) slot.load |-> !slot.busy)
    else $error("slot loaded while a burst is still outstanding");

  // A response beat without an owning burst
  assert property (@(posedge clk_i) disable iff (rst_i) slot.dec |-> slot.busy)
    else $error("slot decremented while idle");

endmodule

// ==== hw/ar_splitter.sv ====
// Request side of the burst splitter. Takes one burst request at a time,
// books its beat count in the next slot of the ring and sends it
// downstream as a run of single-beat requests.
// INCR steps the address by one beat, FIXED repeats it.

`timescale 1ns/1ps

module ar_splitter
  import axi_read_pkg::*;
  import splitter_pkg::*;
#(
  parameter int unsigned NumSlots = 4
) (
  input  logic    clk_i,
  input  logic    rst_i,

  input  logic    s_ar_valid_i,
  output logic    s_ar_ready_o,
  input  addr_t   s_ar_addr_i,
  input  len_t    s_ar_len_i,
  input  size_t   s_ar_size_i,
  input  burst_t  s_ar_burst_i,
  input  id_t     s_ar_id_i,

  output logic    m_ar_valid_o,
  input  logic    m_ar_ready_i,
  output addr_t   m_ar_addr_o,
  output len_t    m_ar_len_o,
  output size_t   m_ar_size_o,
  output burst_t  m_ar_burst_o,
  output id_t     m_ar_id_o,

  slot_if.filler  slots [NumSlots]
);

  localparam int unsigned IdxW = $clog2(NumSlots);
  typedef logic [IdxW-1:0] slot_idx_t;

  split_state_e       state_q;
  slot_idx_t          fill_ptr_q;
  logic [NumSlots-1:0] slot_busy;

  // Current burst
  addr_t  addr_q;
  size_t  size_q;
  burst_t burst_q;
  id_t    id_q;
  len_t   remain_q;

  logic accept;
  logic m_xfer;

  assign accept = s_ar_valid_i && s_ar_ready_o;
  assign m_xfer = m_ar_valid_o && m_ar_ready_i;

  // Per-slot fan-in of busy and fan-out of the load
  for (genvar i = 0; i < NumSlots; i++) begin : gen_slot_io
    assign slot_busy[i]        = slots[i].busy;
    assign slots[i].load       = accept && (fill_ptr_q == slot_idx_t'(i));
    assign slots[i].load_count = beat_cnt_t'(s_ar_len_i) + beat_cnt_t'(1);
  end

  assign s_ar_ready_o = (state_q == Idle) && !slot_busy[fill_ptr_q];

  // --------------------
  // Control
  // --------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q    <= Idle;
      fill_ptr_q <= '0;
    end else begin
      unique case (state_q)
        Idle: begin
          if (accept) begin
            state_q <= Busy;
          end
        end
        Busy: begin
          if (m_xfer && remain_q == '0) begin
            state_q <= Idle;
            // Ring order for any slot count
            if (fill_ptr_q == slot_idx_t'(NumSlots - 1)) begin
              fill_ptr_q <= '0;
            end else begin
              fill_ptr_q <= fill_ptr_q + slot_idx_t'(1);
            end
          end
        end
        default: state_q <= Idle;
      endcase
    end
  end

  // Burst registers, stepped once per downstream request
  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q   <= s_ar_addr_i;
      size_q   <= s_ar_size_i;
      burst_q  <= s_ar_burst_i;
      id_q     <= s_ar_id_i;
      remain_q <= s_ar_len_i;
    end else if (m_xfer) begin
      remain_q <= remain_q - len_t'(1);
      if (burst_q == BURST_INCR) begin
        addr_q <= addr_q + (addr_t'(1) << size_q);
      end
    end
  end

  assign m_ar_valid_o = (state_q == Busy);
  assign m_ar_addr_o  = addr_q;
  assign m_ar_len_o   = '0;
  assign m_ar_size_o  = size_q;
  assign m_ar_burst_o = burst_q;
  assign m_ar_id_o    = id_q;

  // --------------------
  // Checks
  // --------------------
  // WRAP bursts are flagged at the input
  assert property (@(posedge clk_i) disable iff (rst_i)
      accept |-> s_ar_burst_i != BURST_WRAP)
    else $error("WRAP burst accepted, not supported");

endmodule

// ==== hw/r_last_rebuild.sv ====
// Response side of the burst splitter. Passes single-beat responses
// upstream and rebuilds last from the beat count of the oldest burst.
// Combinational path, only the drain pointer is registered.

`timescale 1ns/1ps

module r_last_rebuild
  import axi_read_pkg::*;
  import splitter_pkg::*;
#(
  parameter int unsigned NumSlots = 4
) (
  input  logic    clk_i,
  input  logic    rst_i,

  input  logic    m_r_valid_i,
  output logic    m_r_ready_o,
  input  data_t   m_r_data_i,
  input  id_t     m_r_id_i,

  output logic    s_r_valid_o,
  input  logic    s_r_ready_i,
  output data_t   s_r_data_o,
  output id_t     s_r_id_o,
  output logic    s_r_last_o,

  slot_if.drainer slots [NumSlots]
);

  localparam int unsigned IdxW = $clog2(NumSlots);
  typedef logic [IdxW-1:0] slot_idx_t;

  slot_idx_t           drain_ptr_q;
  logic [NumSlots-1:0] slot_busy;
  beat_cnt_t           slot_count [NumSlots];

  logic head_busy;
  logic r_xfer;

  for (genvar i = 0; i < NumSlots; i++) begin : gen_slot_io
    assign slot_busy[i]  = slots[i].busy;
    assign slot_count[i] = slots[i].count;
    assign slots[i].dec  = r_xfer && (drain_ptr_q == slot_idx_t'(i));
  end

  assign head_busy = slot_busy[drain_ptr_q];

  // --------------------
  // Response path
  // --------------------
  assign s_r_valid_o = m_r_valid_i && head_busy;
  assign m_r_ready_o = s_r_ready_i && head_busy;
  assign s_r_data_o  = m_r_data_i;
  assign s_r_id_o    = m_r_id_i;
  assign s_r_last_o  = (slot_count[drain_ptr_q] == beat_cnt_t'(1));

  assign r_xfer = m_r_valid_i && m_r_ready_o;

  // Move to the next burst once its final beat has gone up
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      drain_ptr_q <= '0;
    end else if (r_xfer && s_r_last_o) begin
      if (drain_ptr_q == slot_idx_t'(NumSlots - 1)) begin
        drain_ptr_q <= '0;
      end else begin
        drain_ptr_q <= drain_ptr_q + slot_idx_t'(1);
      end
    end
  end

  // Downstream may only answer requests that have been booked
  assert property (@(posedge clk_i) disable iff (rst_i) m_r_valid_i |-> head_busy)
    else $error("response beat with no outstanding burst");

endmodule

// ==== hw/read_burst_splitter.sv ====
// Read burst splitter top level. Upstream burst requests leave as
// single-beat requests, their responses return with last rebuilt.
// NumSlots sets how many bursts may be outstanding at once.

`timescale 1ns/1ps

module read_burst_splitter import axi_read_pkg::*; #(
  parameter int unsigned NumSlots = 4
) (
  input  logic   clk_i,
  input  logic   rst_i,

  // Upstream request
  input  logic   s_ar_valid_i,
  output logic   s_ar_ready_o,
  input  addr_t  s_ar_addr_i,
  input  len_t   s_ar_len_i,
  input  size_t  s_ar_size_i,
  input  burst_t s_ar_burst_i,
  input  id_t    s_ar_id_i,

  // Downstream request
  output logic   m_ar_valid_o,
  input  logic   m_ar_ready_i,
  output addr_t  m_ar_addr_o,
  output len_t   m_ar_len_o,
  output size_t  m_ar_size_o,
  output burst_t m_ar_burst_o,
  output id_t    m_ar_id_o,

  // Downstream response
  input  logic   m_r_valid_i,
  output logic   m_r_ready_o,
  input  data_t  m_r_data_i,
  input  id_t    m_r_id_i,

  // Upstream response
  output logic   s_r_valid_o,
  input  logic   s_r_ready_i,
  output data_t  s_r_data_o,
  output id_t    s_r_id_o,
  output logic   s_r_last_o
);

  slot_if slots [NumSlots] ();

  ar_splitter #(
    .NumSlots (NumSlots)
  ) u_ar_splitter (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .s_ar_valid_i (s_ar_valid_i),
    .s_ar_ready_o (s_ar_ready_o),
    .s_ar_addr_i  (s_ar_addr_i),
    .s_ar_len_i   (s_ar_len_i),
    .s_ar_size_i  (s_ar_size_i),
    .s_ar_burst_i (s_ar_burst_i),
    .s_ar_id_i    (s_ar_id_i),
    .m_ar_valid_o (m_ar_valid_o),
    .m_ar_ready_i (m_ar_ready_i),
    .m_ar_addr_o  (m_ar_addr_o),
    .m_ar_len_o   (m_ar_len_o),
    .m_ar_size_o  (m_ar_size_o),
    .m_ar_burst_o (m_ar_burst_o),
    .m_ar_id_o    (m_ar_id_o),
    .slots        (slots)
  );

  // --------------------
  // Beat-count ring
  // --------------------
  for (genvar i = 0; i < NumSlots; i++) begin : gen_slot
    beat_count_slot u_slot (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .slot  (slots[i])
    );
  end

  r_last_rebuild #(
    .NumSlots (NumSlots)
  ) u_r_last_rebuild (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .m_r_valid_i (m_r_valid_i),
    .m_r_ready_o (m_r_ready_o),
    .m_r_data_i  (m_r_data_i),
    .m_r_id_i    (m_r_id_i),
    .s_r_valid_o (s_r_valid_o),
    .s_r_ready_i (s_r_ready_i),
    .s_r_data_o  (s_r_data_o),
    .s_r_id_o    (s_r_id_o),
    .s_r_last_o  (s_r_last_o),
    .slots       (slots)
  );

endmodule

// ==== verification/tb_read_slave.sv ====
// Downstream read memory model for the burst splitter testbench.
// Accepts single-beat requests with random ready, queues them and answers
// each one in order with one response beat after random valid stalls.
// Stall bits come from the testbench top so one random stream drives the run.

`timescale 1ns/1ps

module tb_read_slave import axi_read_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_i,

  input  logic  ar_valid_i,
  output logic  ar_ready_o,
  input  addr_t ar_addr_i,
  input  id_t   ar_id_i,

  output logic  r_valid_o,
  input  logic  r_ready_i,
  output data_t r_data_o,
  output id_t   r_id_o,

  input  logic  ar_stall_i,
  input  logic  r_stall_i
);

  // Requests still waiting for their response beat
  addr_t pend_addr [$];
  id_t   pend_id [$];

  initial begin
    logic in_reset;
    logic ar_stall;
    logic r_stall;
    logic ar_fire;
    logic r_fire;
    ar_ready_o = 1'b0;
    r_valid_o  = 1'b0;
    r_data_o   = '0;
    r_id_o     = '0;
    forever begin
      @(posedge clk_i);
      // Everything is sampled at the edge, outputs change 1 ns later
      in_reset = rst_i;
      ar_stall = ar_stall_i;
      r_stall  = r_stall_i;
      ar_fire  = !in_reset && ar_valid_i && ar_ready_o;
      r_fire   = !in_reset && r_valid_o && r_ready_i;
      if (ar_fire) begin
        pend_addr.push_back(ar_addr_i);
        pend_id.push_back(ar_id_i);
      end
      if (r_fire) begin
        void'(pend_addr.pop_front());
        void'(pend_id.pop_front());
      end
      #1;
      ar_ready_o = !in_reset && !ar_stall;
      if (r_fire || in_reset) begin
        r_valid_o = 1'b0;
      end
      // Present the oldest request's beat, held until it is taken
      if (!in_reset && !r_valid_o && pend_addr.size() != 0 && !r_stall) begin
        r_valid_o = 1'b1;
        r_data_o  = pend_addr[0] ^ 32'h5a5a0000;
        r_id_o    = pend_id[0];
      end
    end
  end

endmodule

// ==== verification/tb_read_burst_splitter.sv ====
// Testbench for the read burst splitter. Sends random INCR and FIXED bursts,
// lets a memory model answer the single-beat requests and checks both the
// downstream requests and the rebuilt upstream bursts against expectations
// built from each accepted request. Random stimulus comes from an LFSR.

`timescale 1ns/1ps

module tb_read_burst_splitter import axi_read_pkg::*; ();

  localparam int unsigned NumSlots      = 4;
  localparam int unsigned NumBursts     = 200;
  localparam int unsigned TimeoutCycles = NumBursts * 16 * 8;

  typedef struct packed {
    addr_t  addr;
    size_t  size;
    burst_t burst;
    id_t    id;
  } ar_exp_t;

  typedef struct packed {
    data_t data;
    id_t   id;
    logic  last;
  } r_exp_t;

  logic   clk_i;
  logic   rst_i;
  logic   s_ar_valid_i;
  logic   s_ar_ready_o;
  addr_t  s_ar_addr_i;
  len_t   s_ar_len_i;
  size_t  s_ar_size_i;
  burst_t s_ar_burst_i;
  id_t    s_ar_id_i;
  logic   m_ar_valid_o;
  logic   m_ar_ready_i;
  addr_t  m_ar_addr_o;
  len_t   m_ar_len_o;
  size_t  m_ar_size_o;
  burst_t m_ar_burst_o;
  id_t    m_ar_id_o;
  logic   m_r_valid_i;
  logic   m_r_ready_o;
  data_t  m_r_data_i;
  id_t    m_r_id_i;
  logic   s_r_valid_o;
  logic   s_r_ready_i;
  data_t  s_r_data_o;
  id_t    s_r_id_o;
  logic   s_r_last_o;

  logic ar_stall;
  logic r_stall;

  logic [31:0] lfsr_q = 32'hd299;
  ar_exp_t     exp_ar [$];
  r_exp_t      exp_r [$];
  int unsigned issued;
  int unsigned done_bursts;
  int unsigned cycles;

  read_burst_splitter #(
    .NumSlots (NumSlots)
  ) uut (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .s_ar_valid_i (s_ar_valid_i),
    .s_ar_ready_o (s_ar_ready_o),
    .s_ar_addr_i  (s_ar_addr_i),
    .s_ar_len_i   (s_ar_len_i),
    .s_ar_size_i  (s_ar_size_i),
    .s_ar_burst_i (s_ar_burst_i),
    .s_ar_id_i    (s_ar_id_i),
    .m_ar_valid_o (m_ar_valid_o),
    .m_ar_ready_i (m_ar_ready_i),
    .m_ar_addr_o  (m_ar_addr_o),
    .m_ar_len_o   (m_ar_len_o),
    .m_ar_size_o  (m_ar_size_o),
    .m_ar_burst_o (m_ar_burst_o),
    .m_ar_id_o    (m_ar_id_o),
    .m_r_valid_i  (m_r_valid_i),
    .m_r_ready_o  (m_r_ready_o),
    .m_r_data_i   (m_r_data_i),
    .m_r_id_i     (m_r_id_i),
    .s_r_valid_o  (s_r_valid_o),
    .s_r_ready_i  (s_r_ready_i),
    .s_r_data_o   (s_r_data_o),
    .s_r_id_o     (s_r_id_o),
    .s_r_last_o   (s_r_last_o)
  );

  tb_read_slave u_slave (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .ar_valid_i (m_ar_valid_o),
    .ar_ready_o (m_ar_ready_i),
    .ar_addr_i  (m_ar_addr_o),
    .ar_id_i    (m_ar_id_o),
    .r_valid_o  (m_r_valid_i),
    .r_ready_i  (m_r_ready_o),
    .r_data_o   (m_r_data_i),
    .r_id_o     (m_r_id_i),
    .ar_stall_i (ar_stall),
    .r_stall_i  (r_stall)
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #50;
      clk_i = ~clk_i;
    end
  end

  // --------------------
  // Random numbers
  // --------------------
  // Taps 32, 22, 2, 1
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_step()};
    end
    return v;
  endfunction

  // --------------------
  // Failure reporting and compares
  // --------------------
  task automatic report_mismatch(input string msg);
    $display("FAIL at %0t: %s", $time, msg);
    $display("TEST FAIL");
    $fatal(1, "stopped on first mismatch");
  endtask

  task automatic abort_run(input string why);
    $display("Error at %0t: %s", $time, why);
    $display("TEST FAIL");
    $fatal(1, "run aborted");
  endtask

  task automatic check_ar(input addr_t got_addr, input addr_t exp_addr, input len_t got_len,
                          input id_t got_id, input id_t exp_id,
                          input size_t got_size, input size_t exp_size,
                          input burst_t got_burst, input burst_t exp_burst);
    if (got_addr !== exp_addr || got_len !== len_t'(0) || got_id !== exp_id ||
        got_size !== exp_size || got_burst !== exp_burst) begin
      report_mismatch($sformatf(
          "AR addr %h len %0d id %h size %0d burst %0d, expected %h 0 %h %0d %0d",
          got_addr, got_len, got_id, got_size, got_burst,
          exp_addr, exp_id, exp_size, exp_burst));
    end
  endtask

  task automatic check_r(input data_t got_data, input data_t exp_data, input id_t got_id,
                         input id_t exp_id, input logic got_last, input logic exp_last);
    if (got_data !== exp_data || got_id !== exp_id || got_last !== exp_last) begin
      report_mismatch($sformatf("R data %h id %h last %b, expected %h %h %b",
                                got_data, got_id, got_last, exp_data, exp_id, exp_last));
    end
  endtask

  // --------------------
  // Stimulus
  // --------------------
  task automatic new_request();
    size_t size;
    size = size_t'(rand_bits(2) % 3);
    s_ar_size_i  = size;
    s_ar_len_i   = len_t'(rand_bits(4));
    s_ar_burst_i = (rand_bits(1) != 0) ? BURST_INCR : BURST_FIXED;
    s_ar_id_i    = id_t'(rand_bits(4));
    // Start aligned to the beat size
    s_ar_addr_i  = rand_bits(32) & ~((addr_t'(1) << size) - addr_t'(1));
    s_ar_valid_i = 1'b1;
  endtask

  // Expected requests and beats of the burst just accepted
  task automatic expect_burst();
    ar_exp_t e_ar;
    r_exp_t  e_r;
    for (int unsigned i = 0; i <= 32'(s_ar_len_i); i++) begin
      e_ar.addr = s_ar_addr_i;
      if (s_ar_burst_i == BURST_INCR) begin
        e_ar.addr = s_ar_addr_i + (addr_t'(i) << s_ar_size_i);
      end
      e_ar.size  = s_ar_size_i;
      e_ar.burst = s_ar_burst_i;
      e_ar.id    = s_ar_id_i;
      exp_ar.push_back(e_ar);
      e_r.data = e_ar.addr ^ 32'h5a5a0000;
      e_r.id   = s_ar_id_i;
      e_r.last = (i == 32'(s_ar_len_i));
      exp_r.push_back(e_r);
    end
  endtask

  initial begin
    logic        ar_fire;
    int unsigned gap;
    s_ar_valid_i = 1'b0;
    s_ar_addr_i  = '0;
    s_ar_len_i   = '0;
    s_ar_size_i  = '0;
    s_ar_burst_i = BURST_INCR;
    s_ar_id_i    = '0;
    s_r_ready_i  = 1'b0;
    ar_stall     = 1'b0;
    r_stall      = 1'b0;
    issued       = 0;
    gap          = 0;
    rst_i        = 1'b1;
    repeat (3) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    forever begin
      @(posedge clk_i);
      ar_fire = s_ar_valid_i && s_ar_ready_o;
      #1;
      if (ar_fire) begin
        expect_burst();
        s_ar_valid_i = 1'b0;
        // Zero gap gives back-to-back bursts
        gap = rand_bits(2);
      end
      if (!s_ar_valid_i && issued < NumBursts) begin
        if (gap == 0) begin
          new_request();
          issued++;
        end else begin
          gap--;
        end
      end
      s_r_ready_i = (rand_bits(2) != 0);
      ar_stall    = (rand_bits(2) == 0);
      r_stall     = (rand_bits(2) == 0);
    end
  end

  // --------------------
  // Monitor and verdict
  // --------------------
  initial begin
    done_bursts = 0;
    cycles      = 0;
  end

  always @(posedge clk_i) begin
    ar_exp_t e_ar;
    r_exp_t  e_r;
    if (!rst_i) begin
      cycles++;
      if (cycles >= TimeoutCycles) begin
        abort_run($sformatf("run timed out after %0d cycles with %0d of %0d bursts done",
                            cycles, done_bursts, NumBursts));
      end
      if (m_ar_valid_o && m_ar_ready_i) begin
        if (exp_ar.size() == 0) begin
          abort_run("downstream request seen while no request was expected");
        end else begin
          e_ar = exp_ar.pop_front();
          check_ar(m_ar_addr_o, e_ar.addr, m_ar_len_o, m_ar_id_o, e_ar.id,
                   m_ar_size_o, e_ar.size, m_ar_burst_o, e_ar.burst);
        end
      end
      if (s_r_valid_o && s_r_ready_i) begin
        if (exp_r.size() == 0) begin
          abort_run("response beat seen while no beat was expected");
        end else begin
          e_r = exp_r.pop_front();
          check_r(s_r_data_o, e_r.data, s_r_id_o, e_r.id, s_r_last_o, e_r.last);
          if (s_r_last_o) begin
            done_bursts++;
          end
        end
      end
      if (done_bursts == NumBursts) begin
        if (exp_ar.size() != 0 || exp_r.size() != 0) begin
          $display("Error: all bursts closed but %0d requests and %0d beats still expected",
                   exp_ar.size(), exp_r.size());
          $display("TEST FAIL");
          $fatal(1, "leftover expectations");
        end else begin
          $display("TEST PASS");
          $finish;
        end
      end
    end
  end

endmodule

// ==== tb.f ====
hw/axi_read_pkg.sv
hw/splitter_pkg.sv
hw/slot_if.sv
hw/beat_count_slot.sv
hw/ar_splitter.sv
hw/r_last_rebuild.sv
hw/read_burst_splitter.sv
verification/tb_read_slave.sv
verification/tb_read_burst_splitter.sv

// ==== Makefile ====
# Verilator flow for the read burst splitter
# Any variable can be overridden, e.g. make sim LOG=run.log

VERILATOR ?= verilator
FILELIST  ?= tb.f
TB_TOP    ?= tb_read_burst_splitter
RTL_TOP   ?= read_burst_splitter
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
JOBS      ?= 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TB_TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
